// File: Bender.yml
package:
  name: tf_slice

sources:
  - logic/tf_pkg.sv
  - logic/tf_mem_if.sv
  - logic/tf_memory.sv
  - logic/projection_router.sv
  - logic/match_engine.sv
  - logic/match_engine_array.sv
  - logic/tf_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_tf_top.sv

// File: bench/tb_tf_cases.svh
`ifndef TB_TF_CASES_SVH
`define TB_TF_CASES_SVH

typedef struct packed {
  logic [8*10-1:0]  name;
  bx_t              bx;
  nent_t            n_proj;
  nent_t [0:N_VM-1] n_stub;
  logic [31:0]      seed_ofs;
  logic             pattern;
} event_t;

// Parity of bx alternates from row to row
localparam int N_EVENTS = 7;
localparam event_t EVENTS [N_EVENTS] = '{
  '{"edges",    3'd2, 7'd8,  '{7'd6,  7'd6,  7'd6,  7'd6},  32'd0,  1'b1},
  '{"rand_b",   3'd3, 7'd33, '{7'd7,  7'd9,  7'd5,  7'd3},  32'd37, 1'b0},
  '{"rand_a",   3'd2, 7'd20, '{7'd8,  7'd4,  7'd0,  7'd10}, 32'd23, 1'b0},
  '{"no_proj",  3'd5, 7'd0,  '{7'd5,  7'd3,  7'd0,  7'd1},  32'd11, 1'b0},
  '{"rand_c",   3'd4, 7'd64, '{7'd10, 7'd10, 7'd10, 7'd10}, 32'd41, 1'b0},
  '{"rand_d",   3'd7, 7'd1,  '{7'd1,  7'd1,  7'd1,  7'd1},  32'd53, 1'b0},
  '{"overflow", 3'd6, 7'd64, '{7'd6,  7'd12, 7'd3,  7'd0},  32'd0,  1'b1}
};

function automatic vmproj_word_t vm_word_of(input proj_word_t w);
  vmproj_word_t v;
  v = '0;
  v[VMP_INDEX_LSB +: INDEX_W] = w[PROJ_INDEX_LSB +: INDEX_W];
  v[VMP_PHI_LSB +: PHI_W]     = w[PROJ_PHI_LSB +: PHI_W];
  v[VMP_Z_LSB +: Z_W]         = w[PROJ_Z_LSB +: Z_W];
  return v;
endfunction

function automatic bit in_window(input vmproj_word_t p, input stub_word_t s);
  int dphi;
  int dz;
  dphi = int'(p[VMP_PHI_LSB +: PHI_W]) - int'(s[VMP_PHI_LSB +: PHI_W]);
  dz   = int'(p[VMP_Z_LSB +: Z_W]) - int'(s[VMP_Z_LSB +: Z_W]);
  return (dphi >= -PHI_WINDOW) && (dphi <= PHI_WINDOW) &&
         (dz >= -Z_WINDOW) && (dz <= Z_WINDOW);
endfunction

function automatic cand_word_t cand_of(input vmproj_word_t p, input stub_word_t s);
  cand_word_t c;
  c = '0;
  c[CAND_PROJ_LSB +: INDEX_W] = p[VMP_INDEX_LSB +: INDEX_W];
  c[CAND_STUB_LSB +: INDEX_W] = s[VMP_INDEX_LSB +: INDEX_W];
  return c;
endfunction

`endif

// File: bench/tb_tf_top.sv
`default_nettype none

module tb_tf_top
  import tf_pkg::*;
();

  localparam int PHI_WINDOW = 4;
  localparam int Z_WINDOW   = 8;

  `include "tb_tf_cases.svh"

  logic       clk;
  logic       arst_n;
  logic       start;
  bx_t        bx_in;
  logic       proj_we;
  addr_t      proj_addr;
  proj_word_t proj_din;
  logic       proj_nent_we;
  nent_t      proj_nent;
  logic       stub_we      [N_VM];
  addr_t      stub_addr    [N_VM];
  stub_word_t stub_din     [N_VM];
  logic       stub_nent_we [N_VM];
  nent_t      stub_nent    [N_VM];
  logic       match_en     [N_VM];
  addr_t      match_addr   [N_VM];
  cand_word_t match_dout   [N_VM];
  nent_t      match_nent   [N_VM];
  bx_t        bx_out;
  logic       done;

  proj_word_t  proj_words [DEPTH];
  stub_word_t  stub_words [N_VM][DEPTH];
  cand_word_t  exp_cands [DEPTH];
  logic [31:0] rng;
  int          waited;
  int          wait_limit;

  tf_top #(
    .PHI_WINDOW(PHI_WINDOW),
    .Z_WINDOW  (Z_WINDOW)
  ) dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .bx_in       (bx_in),
    .proj_we     (proj_we),
    .proj_addr   (proj_addr),
    .proj_din    (proj_din),
    .proj_nent_we(proj_nent_we),
    .proj_nent   (proj_nent),
    .stub_we     (stub_we),
    .stub_addr   (stub_addr),
    .stub_din    (stub_din),
    .stub_nent_we(stub_nent_we),
    .stub_nent   (stub_nent),
    .match_en    (match_en),
    .match_addr  (match_addr),
    .match_dout  (match_dout),
    .match_nent  (match_nent),
    .bx_out      (bx_out),
    .done        (done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Budget for all waits on done over the whole table
  function automatic int wait_budget();
    int total;
    int n_stubs;
    total = 0;
    for (int e = 0; e < N_EVENTS; e++) begin
      n_stubs = 0;
      for (int b = 0; b < N_VM; b++) begin
        n_stubs += EVENTS[e].n_stub[b];
      end
      total += EVENTS[e].n_proj * n_stubs + EVENTS[e].n_proj + 20;
    end
    return total;
  endfunction

  function automatic proj_word_t make_proj(input int i, input vm_t bin, input phi_t phi,
                                           input z_t z);
    proj_word_t w;
    w = '0;
    w[PROJ_INDEX_LSB +: INDEX_W] = index_t'(i);
    w[PROJ_VM_LSB +: VM_W]       = bin;
    w[PROJ_PHI_LSB +: PHI_W]     = phi;
    w[PROJ_Z_LSB +: Z_W]         = z;
    return w;
  endfunction

  function automatic stub_word_t make_stub(input int s, input phi_t phi, input z_t z);
    stub_word_t w;
    w = '0;
    w[VMP_INDEX_LSB +: INDEX_W] = index_t'(s);
    w[VMP_PHI_LSB +: PHI_W]     = phi;
    w[VMP_Z_LSB +: Z_W]         = z;
    return w;
  endfunction

  // Stubs sit on and one step past the window edges around (100, 100)
  function automatic stub_word_t pattern_stub(input int s);
    case (s % 6)
      0:       return make_stub(s, 8'd100, 8'd100);
      1:       return make_stub(s, 8'd104, 8'd92);
      2:       return make_stub(s, 8'd105, 8'd100);
      3:       return make_stub(s, 8'd96, 8'd108);
      4:       return make_stub(s, 8'd100, 8'd109);
      default: return make_stub(s, 8'd95, 8'd91);
    endcase
  endfunction

  task automatic report_mismatch(input string what, input int unsigned exp_val,
                                 input int unsigned act_val);
    $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", what, exp_val, act_val);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic next_cycle();
    @(negedge clk);
    waited++;
    if (waited > wait_limit) begin
      $display("Timeout: done did not arrive within %0d cycles of waiting", wait_limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  endtask

  task automatic build_event(input event_t ev);
    rng = 32'h2021_d525 + ev.seed_ofs;
    for (int i = 0; i < ev.n_proj; i++) begin
      if (ev.pattern) begin
        proj_words[i] = make_proj(i, vm_t'((i * 3) % 4), phi_t'(100 + i % 2), z_t'(100));
      end else begin
        rng = lcg_next(rng);
        proj_words[i] = make_proj(i, rng[31:30], phi_t'(96 + rng[23:20]),
                                  z_t'(96 + rng[19:15]));
      end
    end
    for (int b = 0; b < N_VM; b++) begin
      for (int s = 0; s < ev.n_stub[b]; s++) begin
        if (ev.pattern) begin
          stub_words[b][s] = pattern_stub(s);
        end else begin
          rng = lcg_next(rng);
          stub_words[b][s] = make_stub(s, phi_t'(96 + rng[23:20]), z_t'(96 + rng[19:15]));
        end
      end
    end
  endtask

  task automatic load_event(input event_t ev);
    int n_max;
    n_max = ev.n_proj;
    for (int b = 0; b < N_VM; b++) begin
      if (ev.n_stub[b] > n_max) begin
        n_max = ev.n_stub[b];
      end
    end
    @(posedge clk);
    bx_in <= ev.bx;
    for (int k = 0; k < n_max; k++) begin
      @(posedge clk);
      proj_we   <= (k < ev.n_proj);
      proj_addr <= addr_t'(k);
      proj_din  <= proj_words[k];
      for (int b = 0; b < N_VM; b++) begin
        stub_we[b]   <= (k < ev.n_stub[b]);
        stub_addr[b] <= addr_t'(k);
        stub_din[b]  <= stub_words[b][k];
      end
    end
    @(posedge clk);
    proj_we      <= 1'b0;
    proj_nent_we <= 1'b1;
    proj_nent    <= ev.n_proj;
    for (int b = 0; b < N_VM; b++) begin
      stub_we[b]      <= 1'b0;
      stub_nent_we[b] <= 1'b1;
      stub_nent[b]    <= ev.n_stub[b];
    end
    @(posedge clk);
    proj_nent_we <= 1'b0;
    for (int b = 0; b < N_VM; b++) begin
      stub_nent_we[b] <= 1'b0;
    end
  endtask

  task automatic run_event();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // done of the previous event drops only when the engines restart
    while (done) begin
      next_cycle();
    end
    while (!done) begin
      next_cycle();
    end
  endtask

  task automatic check_bin(input event_t ev, input int b);
    int    n_exp;
    string tag;
    n_exp = 0;
    tag   = $sformatf("%0s bin %0d", ev.name, b);
    for (int p = 0; p < ev.n_proj; p++) begin
      if (proj_words[p][PROJ_VM_LSB +: VM_W] == vm_t'(b)) begin
        for (int s = 0; s < ev.n_stub[b]; s++) begin
          if (in_window(vm_word_of(proj_words[p]), stub_words[b][s]) && n_exp < DEPTH) begin
            exp_cands[n_exp] = cand_of(vm_word_of(proj_words[p]), stub_words[b][s]);
            n_exp++;
          end
        end
      end
    end
    @(negedge clk);
    assert (match_nent[b] == nent_t'(n_exp))
      else report_mismatch({tag, " count"}, n_exp, match_nent[b]);
    for (int a = 0; a < n_exp; a++) begin
      @(posedge clk);
      match_en[b]   <= 1'b1;
      match_addr[b] <= addr_t'(a);
      @(posedge clk);
      match_en[b] <= 1'b0;
      @(negedge clk);
      assert (match_dout[b] == exp_cands[a])
        else report_mismatch($sformatf("%s word %0d", tag, a), exp_cands[a], match_dout[b]);
    end
  endtask

  initial begin
    arst_n       = 1'b0;
    start        = 1'b0;
    bx_in        = '0;
    proj_we      = 1'b0;
    proj_addr    = '0;
    proj_din     = '0;
    proj_nent_we = 1'b0;
    proj_nent    = '0;
    for (int b = 0; b < N_VM; b++) begin
      stub_we[b]      = 1'b0;
      stub_addr[b]    = '0;
      stub_din[b]     = '0;
      stub_nent_we[b] = 1'b0;
      stub_nent[b]    = '0;
      match_en[b]     = 1'b0;
      match_addr[b]   = '0;
    end
    waited     = 0;
    wait_limit = wait_budget();

    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    assert (done == 1'b0) else report_mismatch("reset done", 0, done);
    for (int b = 0; b < N_VM; b++) begin
      assert (match_nent[b] == '0)
        else report_mismatch($sformatf("reset bin %0d count", b), 0, match_nent[b]);
    end

    for (int e = 0; e < N_EVENTS; e++) begin
      build_event(EVENTS[e]);
      load_event(EVENTS[e]);
      run_event();
      assert (bx_out == EVENTS[e].bx)
        else report_mismatch($sformatf("%0s bx_out", EVENTS[e].name), EVENTS[e].bx, bx_out);
      for (int b = 0; b < N_VM; b++) begin
        check_bin(EVENTS[e], b);
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/match_engine.sv
`default_nettype none

module match_engine
  import tf_pkg::*;
#(
  parameter int PHI_WINDOW = 4,
  parameter int Z_WINDOW   = 8
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    start,
  input  bx_t     bx,
  tf_rd_if.reader proj_rd,
  tf_rd_if.reader stub_rd,
  tf_wr_if.writer cand_wr,
  output logic    done
);

  me_state_t    state;
  nent_t        p_idx;
  nent_t        s_idx;
  nent_t        cand_cnt;
  logic         issue;
  logic         last_stub;
  logic         pair_valid;
  logic         hit;
  vmproj_word_t proj;
  stub_word_t   stub;
  phi_t         proj_phi;
  phi_t         stub_phi;
  z_t           proj_z;
  z_t           stub_z;
  phi_t         dphi;
  z_t           dz;
  cand_word_t   cand;

  // One pair per cycle. The projection is fetched with its first stub so both arrive together
  assign issue = (state == ME_SCAN) || (state == ME_NEXT_PROJ &&
                 p_idx != proj_rd.nent && stub_rd.nent != '0);
  assign last_stub = (s_idx + 1'b1 == stub_rd.nent);

  assign proj_rd.page = bx[0];
  assign proj_rd.en   = issue && (state == ME_NEXT_PROJ);
  assign proj_rd.addr = p_idx[ADDR_W-1:0];
  assign stub_rd.page = bx[0];
  assign stub_rd.en   = issue;
  assign stub_rd.addr = s_idx[ADDR_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ME_IDLE;
      p_idx      <= '0;
      s_idx      <= '0;
      pair_valid <= 1'b0;
      done       <= 1'b0;
    end else begin
      pair_valid <= issue;
      case (state)
        ME_IDLE: begin
          if (start) begin
            p_idx <= '0;
            s_idx <= '0;
            done  <= 1'b0;
            state <= ME_NEXT_PROJ;
          end
        end
        ME_NEXT_PROJ, ME_SCAN: begin
          if (!issue) begin
            state <= ME_FINISH;
          end else if (last_stub) begin
            p_idx <= p_idx + 1'b1;
            s_idx <= '0;
            state <= ME_NEXT_PROJ;
          end else begin
            s_idx <= s_idx + 1'b1;
            state <= ME_SCAN;
          end
        end
        ME_FINISH: begin
          done  <= 1'b1;
          state <= ME_IDLE;
        end
        default: state <= ME_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cand_cnt <= '0;
    end else if (state == ME_IDLE && start) begin
      cand_cnt <= '0;
    end else if (hit) begin
      cand_cnt <= cand_cnt + 1'b1;
    end
  end

  assign proj     = proj_rd.data;
  assign stub     = stub_rd.data;
  assign proj_phi = proj[VMP_PHI_LSB +: PHI_W];
  assign stub_phi = stub[VMP_PHI_LSB +: PHI_W];
  assign proj_z   = proj[VMP_Z_LSB +: Z_W];
  assign stub_z   = stub[VMP_Z_LSB +: Z_W];
  assign dphi     = (proj_phi > stub_phi) ? proj_phi - stub_phi : stub_phi - proj_phi;
  assign dz       = (proj_z > stub_z) ? proj_z - stub_z : stub_z - proj_z;

  // Candidates past a full page are dropped
  assign hit = pair_valid && (dphi <= PHI_WINDOW) && (dz <= Z_WINDOW) &&
               (cand_cnt != nent_t'(DEPTH));

  always_comb begin
    cand = '0;
    cand[CAND_PROJ_LSB +: INDEX_W] = proj[VMP_INDEX_LSB +: INDEX_W];
    cand[CAND_STUB_LSB +: INDEX_W] = stub[VMP_INDEX_LSB +: INDEX_W];
  end

  assign cand_wr.we      = hit;
  assign cand_wr.page    = bx[0];
  assign cand_wr.addr    = cand_cnt[ADDR_W-1:0];
  assign cand_wr.data    = cand;
  assign cand_wr.nent_we = (state == ME_FINISH);
  assign cand_wr.nent    = cand_cnt;

  a_cand_addr: assert property (@(posedge clk) disable iff (!arst_n)
    cand_wr.we |=> cand_cnt <= nent_t'(DEPTH));

endmodule

`default_nettype wire

// File: logic/match_engine_array.sv
`default_nettype none

module match_engine_array
  import tf_pkg::*;
#(
  parameter int PHI_WINDOW = 4,
  parameter int Z_WINDOW   = 8
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    start,
  input  bx_t     bx_in,
  tf_rd_if.reader proj_rd [N_VM],
  tf_rd_if.reader stub_rd [N_VM],
  tf_wr_if.writer cand_wr [N_VM],
  output bx_t     bx_out,
  output logic    done
);

  bx_t             bx_q;
  logic [N_VM-1:0] me_done;

  // Event bx for every engine, valid from the cycle after start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bx_q <= '0;
    end else if (start) begin
      bx_q <= bx_in;
    end
  end

  for (genvar g = 0; g < N_VM; g++) begin : g_me
    match_engine #(
      .PHI_WINDOW(PHI_WINDOW),
      .Z_WINDOW  (Z_WINDOW)
    ) u_me (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (start),
      .bx     (bx_q),
      .proj_rd(proj_rd[g]),
      .stub_rd(stub_rd[g]),
      .cand_wr(cand_wr[g]),
      .done   (me_done[g])
    );
  end

  assign bx_out = bx_q;
  assign done   = &me_done;

endmodule

`default_nettype wire

// File: logic/projection_router.sv
`default_nettype none

module projection_router
  import tf_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  logic    start,
  input  bx_t     bx,
  tf_rd_if.reader proj_rd,
  tf_wr_if.writer vm_wr [N_VM],
  output logic    done,
  output bx_t     bx_out
);

  router_state_t state;
  bx_t           bx_q;
  nent_t         rd_cnt;
  logic          rd_issue;
  logic          rd_valid;
  nent_t         bin_cnt [N_VM];
  proj_word_t    word;
  vm_t           word_bin;
  vmproj_word_t  vm_word;

  assign rd_issue = (state == RT_READ) && (rd_cnt != proj_rd.nent);

  // Page follows the incoming bx until the event is accepted
  assign proj_rd.page = (state == RT_IDLE) ? bx[0] : bx_q[0];
  assign proj_rd.en   = rd_issue;
  assign proj_rd.addr = rd_cnt[ADDR_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= RT_IDLE;
      bx_q     <= '0;
      rd_cnt   <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_issue;
      case (state)
        RT_IDLE: begin
          if (start) begin
            bx_q   <= bx;
            rd_cnt <= '0;
            state  <= (proj_rd.nent == '0) ? RT_FINISH : RT_READ;
          end
        end
        RT_READ: begin
          if (rd_issue) begin
            rd_cnt <= rd_cnt + 1'b1;
          end else begin
            // Last word lands this cycle
            state <= RT_FINISH;
          end
        end
        RT_FINISH: state <= RT_IDLE;
        default:   state <= RT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < N_VM; i++) begin
        bin_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_VM; i++) begin
        if (state == RT_IDLE && start) begin
          bin_cnt[i] <= '0;
        end else if (rd_valid && word_bin == vm_t'(i)) begin
          bin_cnt[i] <= bin_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign word     = proj_rd.data;
  assign word_bin = word[PROJ_VM_LSB +: VM_W];
  assign vm_word  = {word[PROJ_INDEX_LSB +: INDEX_W],
                     word[PROJ_PHI_LSB +: PHI_W],
                     word[PROJ_Z_LSB +: Z_W]};

  for (genvar g = 0; g < N_VM; g++) begin : g_bin
    assign vm_wr[g].we      = rd_valid && (word_bin == vm_t'(g));
    assign vm_wr[g].page    = bx_q[0];
    assign vm_wr[g].addr    = bin_cnt[g][ADDR_W-1:0];
    assign vm_wr[g].data    = vm_word;
    assign vm_wr[g].nent_we = (state == RT_FINISH);
    assign vm_wr[g].nent    = bin_cnt[g];
  end

  assign done   = (state == RT_FINISH);
  assign bx_out = bx_q;

  a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> state == RT_IDLE);

endmodule

`default_nettype wire

// File: logic/tf_mem_if.sv
`default_nettype none

interface tf_wr_if
  import tf_pkg::*;
#(
  parameter int WIDTH = 8
);

  logic             we;
  logic             page;
  addr_t            addr;
  logic [WIDTH-1:0] data;
  logic             nent_we;
  nent_t            nent;

  modport writer (output we, page, addr, data, nent_we, nent);
  modport memory (input we, page, addr, data, nent_we, nent);

endinterface

interface tf_rd_if
  import tf_pkg::*;
#(
  parameter int WIDTH = 8
);

  logic             page;
  logic             en;
  addr_t            addr;
  logic [WIDTH-1:0] data;
  nent_t            nent;

  modport reader (output page, en, addr, input data, nent);
  modport memory (input page, en, addr, output data, nent);

endinterface

`default_nettype wire

// File: logic/tf_memory.sv
`default_nettype none

module tf_memory
  import tf_pkg::*;
#(
  parameter int WIDTH = 8
) (
  input  logic    clk,
  input  logic    arst_n,
  tf_wr_if.memory wr,
  tf_rd_if.memory rd
);

  // Two pages back to back, page bit on top of the address
  logic [WIDTH-1:0] mem [2*DEPTH];
  logic [WIDTH-1:0] rd_data;
  nent_t            nent_q [2];

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[{wr.page, wr.addr}] <= wr.data;
    end
  end

  // Output holds its value while en is low
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_data <= mem[{rd.page, rd.addr}];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      nent_q[0] <= '0;
      nent_q[1] <= '0;
    end else if (wr.nent_we) begin
      nent_q[wr.page] <= wr.nent;
    end
  end

  assign rd.data = rd_data;
  assign rd.nent = nent_q[rd.page];

  a_nent_range: assert property (@(posedge clk) disable iff (!arst_n)
    wr.nent_we |=> nent_q[$past(wr.page)] <= nent_t'(DEPTH));

endmodule

`default_nettype wire

// File: logic/tf_pkg.sv
`default_nettype none

package tf_pkg;

  localparam int ADDR_W   = 6;
  localparam int DEPTH    = 1 << ADDR_W;
  localparam int N_VM     = 4;
  localparam int BX_W     = 3;
  localparam int NENT_W   = ADDR_W + 1;
  localparam int VM_W     = 2;
  localparam int PHI_W    = 8;
  localparam int Z_W      = 8;
  localparam int INDEX_W  = 6;
  localparam int PROJ_W   = INDEX_W + VM_W + PHI_W + Z_W;
  localparam int VMPROJ_W = INDEX_W + PHI_W + Z_W;
  localparam int STUB_W   = VMPROJ_W;
  localparam int CAND_W   = 2 * INDEX_W;

  // Input projection word: index | bin | phi | z
  localparam int PROJ_Z_LSB     = 0;
  localparam int PROJ_PHI_LSB   = PROJ_Z_LSB + Z_W;
  localparam int PROJ_VM_LSB    = PROJ_PHI_LSB + PHI_W;
  localparam int PROJ_INDEX_LSB = PROJ_VM_LSB + VM_W;

  // VM projection and VM stub words share one layout
  localparam int VMP_Z_LSB     = 0;
  localparam int VMP_PHI_LSB   = VMP_Z_LSB + Z_W;
  localparam int VMP_INDEX_LSB = VMP_PHI_LSB + PHI_W;

  localparam int CAND_STUB_LSB = 0;
  localparam int CAND_PROJ_LSB = CAND_STUB_LSB + INDEX_W;

  typedef logic [BX_W-1:0]     bx_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [NENT_W-1:0]   nent_t;
  typedef logic [VM_W-1:0]     vm_t;
  typedef logic [PHI_W-1:0]    phi_t;
  typedef logic [Z_W-1:0]      z_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [PROJ_W-1:0]   proj_word_t;
  typedef logic [VMPROJ_W-1:0] vmproj_word_t;
  typedef logic [STUB_W-1:0]   stub_word_t;
  typedef logic [CAND_W-1:0]   cand_word_t;

  typedef enum logic [1:0] {RT_IDLE, RT_READ, RT_FINISH} router_state_t;
  typedef enum logic [1:0] {ME_IDLE, ME_NEXT_PROJ, ME_SCAN, ME_FINISH} me_state_t;

endpackage

`default_nettype wire

// File: logic/tf_top.sv
`default_nettype none

module tf_top
  import tf_pkg::*;
#(
  parameter int PHI_WINDOW = 4,
  parameter int Z_WINDOW   = 8
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  input  bx_t        bx_in,
  input  logic       proj_we,
  input  addr_t      proj_addr,
  input  proj_word_t proj_din,
  input  logic       proj_nent_we,
  input  nent_t      proj_nent,
  input  logic       stub_we      [N_VM],
  input  addr_t      stub_addr    [N_VM],
  input  stub_word_t stub_din     [N_VM],
  input  logic       stub_nent_we [N_VM],
  input  nent_t      stub_nent    [N_VM],
  input  logic       match_en     [N_VM],
  input  addr_t      match_addr   [N_VM],
  output cand_word_t match_dout   [N_VM],
  output nent_t      match_nent   [N_VM],
  output bx_t        bx_out,
  output logic       done
);

  bx_t  router_bx;
  logic router_done;

  tf_wr_if #(.WIDTH(PROJ_W))   proj_load ();
  tf_rd_if #(.WIDTH(PROJ_W))   proj_rd ();
  tf_wr_if #(.WIDTH(VMPROJ_W)) vmproj_wr [N_VM] ();
  tf_rd_if #(.WIDTH(VMPROJ_W)) vmproj_rd [N_VM] ();
  tf_wr_if #(.WIDTH(STUB_W))   stub_load [N_VM] ();
  tf_rd_if #(.WIDTH(STUB_W))   stub_rd [N_VM] ();
  tf_wr_if #(.WIDTH(CAND_W))   cand_wr [N_VM] ();
  tf_rd_if #(.WIDTH(CAND_W))   match_rd [N_VM] ();

  // Loads go to the page of the incoming event
  assign proj_load.we      = proj_we;
  assign proj_load.page    = bx_in[0];
  assign proj_load.addr    = proj_addr;
  assign proj_load.data    = proj_din;
  assign proj_load.nent_we = proj_nent_we;
  assign proj_load.nent    = proj_nent;

  tf_memory #(.WIDTH(PROJ_W)) u_proj_mem (
    .clk   (clk),
    .arst_n(arst_n),
    .wr    (proj_load),
    .rd    (proj_rd)
  );

  for (genvar g = 0; g < N_VM; g++) begin : g_vm
    assign stub_load[g].we      = stub_we[g];
    assign stub_load[g].page    = bx_in[0];
    assign stub_load[g].addr    = stub_addr[g];
    assign stub_load[g].data    = stub_din[g];
    assign stub_load[g].nent_we = stub_nent_we[g];
    assign stub_load[g].nent    = stub_nent[g];

    // Readback from the page of the finished event
    assign match_rd[g].page = bx_out[0];
    assign match_rd[g].en   = match_en[g];
    assign match_rd[g].addr = match_addr[g];
    assign match_dout[g]    = match_rd[g].data;
    assign match_nent[g]    = match_rd[g].nent;

    tf_memory #(.WIDTH(VMPROJ_W)) u_vmproj_mem (
      .clk   (clk),
      .arst_n(arst_n),
      .wr    (vmproj_wr[g]),
      .rd    (vmproj_rd[g])
    );

    tf_memory #(.WIDTH(STUB_W)) u_stub_mem (
      .clk   (clk),
      .arst_n(arst_n),
      .wr    (stub_load[g]),
      .rd    (stub_rd[g])
    );

    tf_memory #(.WIDTH(CAND_W)) u_cand_mem (
      .clk   (clk),
      .arst_n(arst_n),
      .wr    (cand_wr[g]),
      .rd    (match_rd[g])
    );
  end

  projection_router u_router (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .bx     (bx_in),
    .proj_rd(proj_rd),
    .vm_wr  (vmproj_wr),
    .done   (router_done),
    .bx_out (router_bx)
  );

  match_engine_array #(
    .PHI_WINDOW(PHI_WINDOW),
    .Z_WINDOW  (Z_WINDOW)
  ) u_me_array (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (router_done),
    .bx_in  (router_bx),
    .proj_rd(vmproj_rd),
    .stub_rd(stub_rd),
    .cand_wr(cand_wr),
    .bx_out (bx_out),
    .done   (done)
  );

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
logic/tf_pkg.sv
logic/tf_mem_if.sv
logic/tf_memory.sv
logic/projection_router.sv
logic/match_engine.sv
logic/match_engine_array.sv
logic/tf_top.sv
bench/tb_tf_top.sv
